//--- design/cache_gen_defines.svh
`ifndef CACHE_GEN_DEFINES_SVH
`define CACHE_GEN_DEFINES_SVH

// packet field widths
`define CPU_ADDR_WIDTH      32
`define BLOCK_WIDTH         128
`define BYTE_MASK_WIDTH     16
`define PORT_ID_WIDTH       4
`define BLOCK_OFFSET_WIDTH  4

// traffic shape
`define NUM_REQUEST         16
`define BASE_ADDR           32'h1000

// longest gap allowed between two read returns
`define TIMEOUT_CYCLES      200

`endif

//--- design/cache_packet_generator.sv
`timescale 1ns/1ps

module cache_packet_generator
(
    input  logic                              clk_in,
    input  logic                              reset_in,
    output cache_packet_pkg::cache_packet_t   request_packet [2],
    input  logic [1:0]                        request_ack,
    input  cache_packet_pkg::cache_packet_t   return_packet,
    output logic                              return_ack,
    output logic                              done,
    output logic                              error
);

logic                              write_enable;
logic                              read_enable;
logic                              write_finished;
traffic_ctrl_pkg::checker_status_t status;

// way 0 streams the writes
packet_sender #(
    .IS_WRITE (1'b1),
    .PORT_ID  (0)
) u_write_way (
    .clk_in   (clk_in),
    .reset_in (reset_in),
    .enable   (write_enable),
    .ack      (request_ack[0]),
    .packet   (request_packet[0]),
    .finished (write_finished)
);

// way 1 reads the same blocks back, completion is seen through the checker
packet_sender #(
    .IS_WRITE (1'b0),
    .PORT_ID  (1)
) u_read_way (
    .clk_in   (clk_in),
    .reset_in (reset_in),
    .enable   (read_enable),
    .ack      (request_ack[1]),
    .packet   (request_packet[1]),
    .finished ()
);

return_checker u_return_checker (
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .armed      (read_enable),
    .return_pkt (return_packet),
    .return_ack (return_ack),
    .status     (status)
);

test_sequencer u_test_sequencer (
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .write_finished (write_finished),
    .status         (status),
    .write_enable   (write_enable),
    .read_enable    (read_enable),
    .done           (done)
);

assign error = status.error;

endmodule

//--- design/cache_packet_pkg.sv
`include "cache_gen_defines.svh"

package cache_packet_pkg;

    // only data requests are generated
    typedef enum logic [1:0]
    {
        PKT_DATA  = 2'd0,
        PKT_INSTR = 2'd1
    } packet_type_e;

    // field order follows the unified cache packet, cacheable bit on top
    typedef struct packed
    {
        logic                          cacheable;
        logic                          is_write;
        logic                          valid;
        logic [`PORT_ID_WIDTH-1:0]     port_num;
        logic [`BYTE_MASK_WIDTH-1:0]   byte_mask;
        packet_type_e                  pkt_type;
        logic [`BLOCK_WIDTH-1:0]       data;
        logic [`CPU_ADDR_WIDTH-1:0]    addr;
    } cache_packet_t;

    // request index copied into every 32-bit word of a block
    function automatic logic [`BLOCK_WIDTH-1:0] index_pattern(input logic [31:0] index);
        logic [`BLOCK_WIDTH-1:0] pattern;
        pattern = {(`BLOCK_WIDTH / 32){index}};
        return pattern;
    endfunction

endpackage

//--- design/packet_sender.sv
`timescale 1ns/1ps
`include "cache_gen_defines.svh"

module packet_sender
#(
    parameter bit IS_WRITE = 1'b1,
    parameter int PORT_ID  = 0
)
(
    input  logic                            clk_in,
    input  logic                            reset_in,
    input  logic                            enable,
    input  logic                            ack,
    output cache_packet_pkg::cache_packet_t packet,
    output logic                            finished
);

localparam int INDEX_WIDTH = $clog2(`NUM_REQUEST);
localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(`NUM_REQUEST - 1);

logic [INDEX_WIDTH-1:0]          request_index;
logic [`CPU_ADDR_WIDTH-1:0]      block_addr;
cache_packet_pkg::cache_packet_t next_packet;

// one block per request
assign block_addr = `BASE_ADDR
                  + ({{(`CPU_ADDR_WIDTH - INDEX_WIDTH){1'b0}}, request_index}
                     << `BLOCK_OFFSET_WIDTH);

always_comb
begin
    next_packet.cacheable = 1'b1;
    next_packet.is_write  = IS_WRITE;
    next_packet.valid     = 1'b1;
    next_packet.port_num  = `PORT_ID_WIDTH'(PORT_ID);
    next_packet.byte_mask = IS_WRITE ? {`BYTE_MASK_WIDTH{1'b1}} : '0;
    next_packet.pkt_type  = cache_packet_pkg::PKT_DATA;
    // reads carry no payload
    next_packet.data      = IS_WRITE ? cache_packet_pkg::index_pattern(32'(request_index)) : '0;
    next_packet.addr      = block_addr;
end

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        packet        <= '0;
        request_index <= '0;
        finished      <= 1'b0;
    end
    else if (!enable)
    begin
        packet        <= '0;
        request_index <= '0;
        finished      <= 1'b0;
    end
    else if (packet.valid && ack)
    begin
        // gap of one idle cycle after every accepted request
        packet        <= '0;
        request_index <= request_index + 1'b1;
        finished      <= (request_index == LAST_INDEX);
    end
    else if (!packet.valid && !finished)
    begin
        packet <= next_packet;
    end
end

endmodule

//--- design/return_checker.sv
`timescale 1ns/1ps
`include "cache_gen_defines.svh"

module return_checker
(
    input  logic                              clk_in,
    input  logic                              reset_in,
    input  logic                              armed,
    input  cache_packet_pkg::cache_packet_t   return_pkt,
    output logic                              return_ack,
    output traffic_ctrl_pkg::checker_status_t status
);

localparam int INDEX_WIDTH = $clog2(`NUM_REQUEST);
localparam int TIMER_WIDTH = $clog2(`TIMEOUT_CYCLES + 1);
localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(`NUM_REQUEST - 1);
localparam logic [TIMER_WIDTH-1:0] TIMER_LIMIT = TIMER_WIDTH'(`TIMEOUT_CYCLES - 1);

logic [INDEX_WIDTH-1:0] expected_index;
logic [TIMER_WIDTH-1:0] wait_cycles;
logic                   take;
logic                   data_match;

// a return held over the ack cycle is not taken twice
assign take = armed & return_pkt.valid & ~return_ack;

// returns come back in request order
assign data_match = (return_pkt.data
                     == cache_packet_pkg::index_pattern(32'(expected_index)));

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        return_ack     <= 1'b0;
        status         <= '0;
        expected_index <= '0;
        wait_cycles    <= '0;
    end
    else
    begin
        return_ack <= take;

        if (take)
        begin
            wait_cycles    <= '0;
            expected_index <= expected_index + 1'b1;
            if (!data_match)
            begin
                status.error <= 1'b1;
            end
            else if (expected_index == LAST_INDEX && !status.error)
            begin
                status.all_returned <= 1'b1;
            end
        end
        else if (armed && !status.all_returned)
        begin
            // too long without a return
            if (wait_cycles == TIMER_LIMIT)
            begin
                status.error <= 1'b1;
            end
            else
            begin
                wait_cycles <= wait_cycles + 1'b1;
            end
        end
        else
        begin
            wait_cycles <= '0;
        end
    end
end

endmodule

//--- design/test_sequencer.sv
`timescale 1ns/1ps

module test_sequencer
(
    input  logic                              clk_in,
    input  logic                              reset_in,
    input  logic                              write_finished,
    input  traffic_ctrl_pkg::checker_status_t status,
    output logic                              write_enable,
    output logic                              read_enable,
    output logic                              done
);

traffic_ctrl_pkg::phase_e phase;
traffic_ctrl_pkg::phase_e next_phase;

always_comb
begin
    next_phase = phase;
    case (phase)
        traffic_ctrl_pkg::PHASE_IDLE:
        begin
            next_phase = traffic_ctrl_pkg::PHASE_WRITE;
        end
        traffic_ctrl_pkg::PHASE_WRITE:
        begin
            if (status.error)
                next_phase = traffic_ctrl_pkg::PHASE_HALT;
            else if (write_finished)
                next_phase = traffic_ctrl_pkg::PHASE_READ;
        end
        traffic_ctrl_pkg::PHASE_READ:
        begin
            if (status.error)
                next_phase = traffic_ctrl_pkg::PHASE_HALT;
            else if (status.all_returned)
                next_phase = traffic_ctrl_pkg::PHASE_DONE;
        end
        // done and halt hold until reset
        traffic_ctrl_pkg::PHASE_DONE,
        traffic_ctrl_pkg::PHASE_HALT:
        begin
            next_phase = phase;
        end
        default:
        begin
            next_phase = traffic_ctrl_pkg::PHASE_HALT;
        end
    endcase
end

always_ff @(posedge clk_in)
begin
    if (reset_in)
        phase <= traffic_ctrl_pkg::PHASE_IDLE;
    else
        phase <= next_phase;
end

// read enable also arms the checker
assign write_enable = (phase == traffic_ctrl_pkg::PHASE_WRITE);
assign read_enable  = (phase == traffic_ctrl_pkg::PHASE_READ);
assign done         = (phase == traffic_ctrl_pkg::PHASE_DONE);

endmodule

//--- design/traffic_ctrl_pkg.sv
package traffic_ctrl_pkg;

    // write phase first, then read back
    typedef enum logic [2:0]
    {
        PHASE_IDLE  = 3'd0,
        PHASE_WRITE = 3'd1,
        PHASE_READ  = 3'd2,
        PHASE_DONE  = 3'd3,
        PHASE_HALT  = 3'd4
    } phase_e;

    // checker result seen by the sequencer
    typedef struct packed
    {
        logic all_returned;
        logic error;
    } checker_status_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is judged from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module cache_packet_generator_tb \
    -o sim_top
./obj_dir/sim_top | tee sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
fi
exit 1

//--- sim/cache_gen_assertions.sv
`timescale 1ns/1ps

module cache_gen_assertions
(
    input logic                            clk_in,
    input logic                            reset_in,
    input cache_packet_pkg::cache_packet_t write_packet,
    input cache_packet_pkg::cache_packet_t read_packet,
    input logic [1:0]                      request_ack,
    input logic                            write_enable,
    input logic                            read_enable,
    input logic                            return_ack,
    input logic                            done,
    input logic                            error
);

int failures = 0;

// an unacked request holds while its way is enabled
write_request_held: assert property (@(posedge clk_in) disable iff (reset_in)
    (write_packet.valid && !request_ack[0] && write_enable) |=> $stable(write_packet))
    else
    begin
        failures = failures + 1;
        $error("way 0 request changed before its ack");
    end

read_request_held: assert property (@(posedge clk_in) disable iff (reset_in)
    (read_packet.valid && !request_ack[1] && read_enable) |=> $stable(read_packet))
    else
    begin
        failures = failures + 1;
        $error("way 1 request changed before its ack");
    end

return_ack_single: assert property (@(posedge clk_in) disable iff (reset_in)
    return_ack |=> !return_ack)
    else
    begin
        failures = failures + 1;
        $error("return_ack high for two cycles");
    end

done_error_exclusive: assert property (@(posedge clk_in) disable iff (reset_in)
    !(done && error))
    else
    begin
        failures = failures + 1;
        $error("done and error both high");
    end

endmodule

bind cache_packet_generator cache_gen_assertions u_assertions
(
    .clk_in       (clk_in),
    .reset_in     (reset_in),
    .write_packet (request_packet[0]),
    .read_packet  (request_packet[1]),
    .request_ack  (request_ack),
    .write_enable (write_enable),
    .read_enable  (read_enable),
    .return_ack   (return_ack),
    .done         (done),
    .error        (error)
);

//--- sim/cache_model.sv
`timescale 1ns/1ps
`include "cache_gen_defines.svh"

module cache_model
(
    input  logic                            clk_in,
    input  logic                            reset_in,
    input  cache_packet_pkg::cache_packet_t request_packet [2],
    output logic [1:0]                      request_ack,
    output cache_packet_pkg::cache_packet_t return_packet,
    input  logic                            return_ack
);

// controls, written by the testbench on the falling edge
int ack_delay;
int stall_index;
int stall_cycles;
int corrupt_index;
bit silent;

// requests in ack order
cache_packet_pkg::cache_packet_t write_log [`NUM_REQUEST];
cache_packet_pkg::cache_packet_t read_log [`NUM_REQUEST];
int write_count;
int read_count;
int early_reads;

logic [`BLOCK_WIDTH-1:0]         mem [logic [`CPU_ADDR_WIDTH-1:0]];
cache_packet_pkg::cache_packet_t pending [$];
int                              wait_cycles [2];

function automatic int block_index(input logic [`CPU_ADDR_WIDTH-1:0] addr);
    return int'((addr - `BASE_ADDR) >> `BLOCK_OFFSET_WIDTH);
endfunction

task automatic accept_request(input int way);
    cache_packet_pkg::cache_packet_t ret;
    if (way == 0)
    begin
        if (write_count < `NUM_REQUEST)
            write_log[write_count] = request_packet[0];
        write_count = write_count + 1;
        mem[request_packet[0].addr] = request_packet[0].data;
    end
    else
    begin
        if (read_count < `NUM_REQUEST)
            read_log[read_count] = request_packet[1];
        read_count = read_count + 1;
        ret = request_packet[1];
        ret.data = mem.exists(ret.addr) ? mem[ret.addr] : '0;
        // fault injection on one block
        if (block_index(ret.addr) == corrupt_index)
            ret.data[0] = ~ret.data[0];
        pending.push_back(ret);
    end
endtask

initial
begin
    request_ack   = 2'b00;
    return_packet = '0;
end

always @(negedge clk_in)
begin
    int limit;
    if (reset_in)
    begin
        request_ack   = 2'b00;
        return_packet = '0;
        write_count   = 0;
        read_count    = 0;
        early_reads   = 0;
        wait_cycles   = '{0, 0};
        pending.delete();
        mem.delete();
    end
    else
    begin
        // a read must not show up before every write is acked
        if (request_packet[1].valid && write_count < `NUM_REQUEST)
            early_reads = early_reads + 1;
        for (int w = 0; w < 2; w++)
        begin
            if (request_ack[w])
            begin
                request_ack[w] = 1'b0;
                wait_cycles[w] = 0;
            end
            else if (request_packet[w].valid)
            begin
                limit = ack_delay;
                if (w == 0 && block_index(request_packet[0].addr) == stall_index)
                    limit = stall_cycles;
                if (wait_cycles[w] >= limit)
                begin
                    request_ack[w] = 1'b1;
                    accept_request(w);
                end
                else
                    wait_cycles[w] = wait_cycles[w] + 1;
            end
        end
        // return path, one block in flight
        if (return_ack)
            return_packet = '0;
        else if (!return_packet.valid && pending.size() > 0 && !silent)
            return_packet = pending.pop_front();
    end
end

endmodule

//--- sim/cache_packet_generator_tb.sv
`timescale 1ns/1ps
`include "cache_gen_defines.svh"

module cache_packet_generator_tb;

localparam int CYCLE_LIMIT = 8 * (`NUM_REQUEST * 20 + `TIMEOUT_CYCLES);

logic                            clk_in;
logic                            reset_in;
cache_packet_pkg::cache_packet_t request_packet [2];
logic [1:0]                      request_ack;
cache_packet_pkg::cache_packet_t return_packet;
logic                            return_ack;
logic                            done;
logic                            error;
integer                          seed;
int                              cycle_count = 0;

cache_packet_generator u_cache_packet_generator (
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .request_packet (request_packet),
    .request_ack    (request_ack),
    .return_packet  (return_packet),
    .return_ack     (return_ack),
    .done           (done),
    .error          (error)
);

cache_model u_cache_model (
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .request_packet (request_packet),
    .request_ack    (request_ack),
    .return_packet  (return_packet),
    .return_ack     (return_ack)
);

initial
begin
    clk_in = 1'b0;
    forever
        #2 clk_in = ~clk_in;
end

// run limit and bound assertion watch
always @(negedge clk_in)
begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT)
    begin
        $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $fatal(1, "cycle limit reached");
    end
    else if (u_cache_packet_generator.u_assertions.failures != 0)
    begin
        $display("a concurrent assertion on the DUT failed");
        $display("Simulation failed");
        $fatal(1, "assertion failure");
    end
end

function automatic logic [`BLOCK_WIDTH-1:0] expected_data(input int index);
    logic [`BLOCK_WIDTH-1:0] pattern;
    for (int w = 0; w < `BLOCK_WIDTH / 32; w++)
    begin
        pattern[w*32 +: 32] = index;
    end
    return pattern;
endfunction

function automatic logic [`CPU_ADDR_WIDTH-1:0] expected_addr(input int index);
    return `BASE_ADDR + (index << `BLOCK_OFFSET_WIDTH);
endfunction

task automatic check_value(input string test_name, input logic [`BLOCK_WIDTH-1:0] expected,
                           input logic [`BLOCK_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
        $display("** Error %s: expected %0h, actual %0h", test_name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "check mismatch");
    end
endtask

// reset for two cycles with fresh model controls
task automatic start_test(input string test_name, input int delay, input int stall_idx,
                          input int stall_len, input int corrupt_idx, input bit quiet);
    @(negedge clk_in);
    reset_in <= 1'b1;
    u_cache_model.ack_delay     <= delay;
    u_cache_model.stall_index   <= stall_idx;
    u_cache_model.stall_cycles  <= stall_len;
    u_cache_model.corrupt_index <= corrupt_idx;
    u_cache_model.silent        <= quiet;
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    // outputs idle under reset
    check_value({test_name, " reset done"}, 0, done);
    check_value({test_name, " reset error"}, 0, error);
    check_value({test_name, " reset return_ack"}, 0, return_ack);
    check_value({test_name, " reset way 0 valid"}, 0, request_packet[0].valid);
    check_value({test_name, " reset way 1 valid"}, 0, request_packet[1].valid);
    reset_in <= 1'b0;
endtask

task automatic wait_for_end(input bit random_acks);
    do
    begin
        @(negedge clk_in);
        if (random_acks)
            u_cache_model.ack_delay <= $unsigned($random(seed)) % 4;
    end
    while (!done && !error);
endtask

task automatic test_write_stream();
    cache_packet_pkg::cache_packet_t pkt;
    start_test("test_write_stream", 0, -1, 0, -1, 1'b0);
    wait_for_end(1'b0);
    check_value("test_write_stream done", 1, done);
    check_value("test_write_stream count", `NUM_REQUEST, u_cache_model.write_count);
    for (int i = 0; i < `NUM_REQUEST; i++)
    begin
        pkt = u_cache_model.write_log[i];
        check_value("test_write_stream addr", expected_addr(i), pkt.addr);
        check_value("test_write_stream data", expected_data(i), pkt.data);
        check_value("test_write_stream mask", {`BYTE_MASK_WIDTH{1'b1}}, pkt.byte_mask);
        check_value("test_write_stream is_write", 1, pkt.is_write);
        check_value("test_write_stream port", 0, pkt.port_num);
        check_value("test_write_stream cacheable", 1, pkt.cacheable);
        check_value("test_write_stream type", cache_packet_pkg::PKT_DATA, pkt.pkt_type);
    end
endtask

task automatic test_read_after_write();
    cache_packet_pkg::cache_packet_t pkt;
    start_test("test_read_after_write", 0, -1, 0, -1, 1'b0);
    wait_for_end(1'b0);
    check_value("test_read_after_write early reads", 0, u_cache_model.early_reads);
    check_value("test_read_after_write count", `NUM_REQUEST, u_cache_model.read_count);
    for (int i = 0; i < `NUM_REQUEST; i++)
    begin
        pkt = u_cache_model.read_log[i];
        check_value("test_read_after_write addr", expected_addr(i), pkt.addr);
        check_value("test_read_after_write mask", 0, pkt.byte_mask);
        check_value("test_read_after_write is_write", 0, pkt.is_write);
        check_value("test_read_after_write port", 1, pkt.port_num);
    end
endtask

task automatic test_clean_run();
    start_test("test_clean_run", 0, -1, 0, -1, 1'b0);
    wait_for_end(1'b1);
    check_value("test_clean_run done", 1, done);
    check_value("test_clean_run error", 0, error);
    // done is a level
    repeat (20)
    begin
        @(negedge clk_in);
        check_value("test_clean_run done held", 1, done);
        check_value("test_clean_run error held", 0, error);
    end
endtask

task automatic test_corrupt_return();
    start_test("test_corrupt_return", 0, -1, 0, 5, 1'b0);
    wait_for_end(1'b0);
    check_value("test_corrupt_return error", 1, error);
    check_value("test_corrupt_return done", 0, done);
endtask

task automatic test_return_timeout();
    int waited;
    start_test("test_return_timeout", 0, -1, 0, -1, 1'b1);
    while (!request_packet[1].valid)
        @(negedge clk_in);
    waited = 0;
    while (!error && waited < `TIMEOUT_CYCLES + 4)
    begin
        @(negedge clk_in);
        waited = waited + 1;
    end
    check_value("test_return_timeout error", 1, error);
    check_value("test_return_timeout done", 0, done);
endtask

task automatic test_backpressure();
    cache_packet_pkg::cache_packet_t held_packet;
    int held;
    held = 0;
    start_test("test_backpressure", 0, 3, 10, -1, 1'b0);
    do
    begin
        @(negedge clk_in);
        if (request_packet[0].valid && request_packet[0].addr == expected_addr(3))
        begin
            if (held == 0)
                held_packet = request_packet[0];
            check_value("test_backpressure stable", 1, request_packet[0] == held_packet);
            held = held + 1;
        end
    end
    while (!done && !error);
    // ten cycles of waiting plus the ack cycle
    check_value("test_backpressure held cycles", 11, held);
    check_value("test_backpressure done", 1, done);
    check_value("test_backpressure error", 0, error);
endtask

initial
begin
    reset_in = 1'b1;
    seed     = 32'h2991;
    u_cache_model.ack_delay     = 0;
    u_cache_model.stall_index   = -1;
    u_cache_model.stall_cycles  = 0;
    u_cache_model.corrupt_index = -1;
    u_cache_model.silent        = 1'b0;
    test_write_stream();
    test_read_after_write();
    test_clean_run();
    test_corrupt_return();
    test_return_timeout();
    test_backpressure();
    $display("Simulation passed");
    $finish;
end

endmodule

//--- verilog.f
+incdir+design
design/cache_packet_pkg.sv
design/traffic_ctrl_pkg.sv
design/packet_sender.sv
design/return_checker.sv
design/test_sequencer.sv
design/cache_packet_generator.sv
sim/cache_model.sv
sim/cache_gen_assertions.sv
sim/cache_packet_generator_tb.sv
